/* Bender.yml */
package:
  name: store_path

sources:
  - include_dirs:
      - .
    files:
      - cache_pkg.sv
      - rr_arbiter.sv
      - store_buffer.sv
      - store_path_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_store_path.sv

/* all.f */
+incdir+.
cache_pkg.sv
rr_arbiter.sv
store_buffer.sv
store_path_top.sv
tb_store_path.sv

/* cache_macros.svh */
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Number of hardware strands sharing the L1 data cache
// Each strand owns exactly one store buffer entry
`define STRAND_COUNT 4

// Line address fields as seen by the L1 data cache
// The L2 request address is the tag followed by the set index
`define L1_TAG_WIDTH 16
`define L1_SET_INDEX_WIDTH 10

// Cache line payload in bits
`define LINE_WIDTH 512

// One byte enable per byte of the line
`define MASK_WIDTH 64

// Unit ID that tags L2 traffic belonging to the store buffer
// Responses carrying any other ID are meant for other L1 units
`define UNIT_STBUF 2

`endif

/* cache_pkg.sv */
package cache_pkg;

	`include "cache_macros.svh"

	// Operations understood by the L2 cache
	// Only the store buffer ops are produced in this design, loads come from the miss path
	typedef enum logic [2:0]
	{
		L2OP_LOAD       = 3'd0,
		L2OP_STORE      = 3'd1,
		L2OP_STORE_SYNC = 3'd2,
		L2OP_FLUSH      = 3'd3
	} l2_op_t;

	// ID of the L1 unit that owns a request or a response
	typedef logic [1:0] unit_t;

	// Hardware strand index
	// Sized to cover STRAND_COUNT strands
	typedef logic [1:0] strand_t;

endpackage

/* rr_arbiter.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module rr_arbiter
#(
	parameter int NUM_REQ = `STRAND_COUNT
)
(
	input  logic               clk,
	input  logic               reset_n,
	input  logic [NUM_REQ-1:0] request_i,
	input  logic               advance_i,
	output logic [NUM_REQ-1:0] grant_oh_o
);

	// A single requester still needs a one bit pointer
	localparam int PTR_WIDTH = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

	// Index of the requester that has the highest priority this cycle
	logic [PTR_WIDTH-1:0] priority_ptr;
	// Requests at or above the pointer, searched before the wrapped ones
	logic [NUM_REQ-1:0]   upper_request;
	logic [PTR_WIDTH-1:0] grant_idx;
	logic                 grant_found;
	// Grant that was presented but not accepted in the previous cycle
	logic                 hold_valid;
	logic [PTR_WIDTH-1:0] held_idx;

	always_comb
	begin
		for (int i = 0; i < NUM_REQ; i++)
			upper_request[i] = request_i[i] && (i >= priority_ptr);

		grant_oh_o = '0;
		grant_idx = '0;
		grant_found = 1'b0;

		// First pass looks from the pointer up to the top requester
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if (!grant_found && upper_request[i])
			begin
				grant_oh_o[i] = 1'b1;
				grant_idx = PTR_WIDTH'(i);
				grant_found = 1'b1;
			end
		end

		// Second pass wraps around to the requesters below the pointer
		for (int i = 0; i < NUM_REQ; i++)
		begin
			if (!grant_found && request_i[i])
			begin
				grant_oh_o[i] = 1'b1;
				grant_idx = PTR_WIDTH'(i);
				grant_found = 1'b1;
			end
		end

		// A stalled grant stays put even if a higher priority request shows up meanwhile
		if (hold_valid && request_i[held_idx])
		begin
			grant_oh_o = '0;
			grant_oh_o[held_idx] = 1'b1;
			grant_idx = held_idx;
		end
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			priority_ptr <= '0;
			hold_valid <= 1'b0;
			held_idx <= '0;
		end
		else
		begin
			hold_valid <= grant_found && !advance_i;
			held_idx <= grant_idx;

			// The grantee drops to lowest priority once its grant is taken
			if (grant_found && advance_i)
			begin
				if (grant_idx == PTR_WIDTH'(NUM_REQ - 1))
					priority_ptr <= '0;
				else
					priority_ptr <= grant_idx + 1'b1;
			end
		end
	end

endmodule

/* store_buffer.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module store_buffer
(
	input  logic                                         clk,
	input  logic                                         reset_n,

	// Strand pipeline request
	input  logic                                         dcache_store_i,
	input  logic                                         dcache_flush_i,
	input  logic                                         dcache_stbar_i,
	input  logic                                         synchronized_i,
	input  cache_pkg::strand_t                           strand_i,
	input  logic [`L1_TAG_WIDTH-1:0]                     requested_tag_i,
	input  logic [`L1_SET_INDEX_WIDTH-1:0]               requested_set_i,
	input  logic [`LINE_WIDTH-1:0]                       data_i,
	input  logic [`MASK_WIDTH-1:0]                       mask_i,

	// Strand pipeline results
	output logic [`LINE_WIDTH-1:0]                       data_o,
	output logic [`MASK_WIDTH-1:0]                       mask_o,
	output logic                                         rollback_o,
	output logic [`STRAND_COUNT-1:0]                     store_resume_strands_o,
	output logic                                         store_update_o,
	output logic [`L1_SET_INDEX_WIDTH-1:0]               store_update_set_o,

	// L2 request
	output logic                                         l2req_valid_o,
	input  logic                                         l2req_ready_i,
	output cache_pkg::l2_op_t                            l2req_op_o,
	output cache_pkg::unit_t                             l2req_unit_o,
	output cache_pkg::strand_t                           l2req_strand_o,
	output logic [`L1_TAG_WIDTH+`L1_SET_INDEX_WIDTH-1:0] l2req_address_o,
	output logic [`LINE_WIDTH-1:0]                       l2req_data_o,
	output logic [`MASK_WIDTH-1:0]                       l2req_mask_o,

	// L2 response
	input  logic                                         l2rsp_valid_i,
	input  cache_pkg::unit_t                             l2rsp_unit_i,
	input  cache_pkg::strand_t                           l2rsp_strand_i,
	input  logic                                         l2rsp_status_i,
	input  logic                                         l2rsp_update_i,

	// Number of stores accepted into the buffer
	output logic [63:0]                                  store_count_o
);

	import cache_pkg::*;

	// Entry control state, one bit per strand
	logic [`STRAND_COUNT-1:0]       store_enqueued;
	logic [`STRAND_COUNT-1:0]       store_acknowledged;
	logic [`STRAND_COUNT-1:0]       store_flush;
	logic [`STRAND_COUNT-1:0]       store_synchronized;

	// Entry payload
	logic [`L1_TAG_WIDTH-1:0]       store_tag [`STRAND_COUNT];
	logic [`L1_SET_INDEX_WIDTH-1:0] store_set [`STRAND_COUNT];
	logic [`LINE_WIDTH-1:0]         store_data [`STRAND_COUNT];
	logic [`MASK_WIDTH-1:0]         store_mask [`STRAND_COUNT];

	logic [`STRAND_COUNT-1:0]       issue_oh;
	strand_t                        issue_idx;

	// Strands that were rolled back on a full entry and wait for its response
	logic [`STRAND_COUNT-1:0]       store_wait_strands;
	logic                           stbuf_full;

	// Synchronized store bookkeeping
	logic [`STRAND_COUNT-1:0]       sync_store_wait;
	logic [`STRAND_COUNT-1:0]       sync_store_complete;
	logic [`STRAND_COUNT-1:0]       sync_store_result;
	logic [`STRAND_COUNT-1:0]       sync_req_mask;
	logic                           need_sync_rollback;
	logic                           need_sync_rollback_latched;

	logic [`STRAND_COUNT-1:0]       strand_mask;
	logic [`STRAND_COUNT-1:0]       l2_ack_mask;
	logic                           rsp_for_stbuf;
	logic                           l2_store_complete;
	logic                           any_store_op;
	logic                           store_collision;
	logic                           enqueue;
	logic [`LINE_WIDTH-1:0]         bypass_data;
	logic [`MASK_WIDTH-1:0]         bypass_mask;
	logic [63:0]                    store_count;

	assign strand_mask = {{(`STRAND_COUNT-1){1'b0}}, 1'b1} << strand_i;

	// Stores, flushes and barriers all need the entry to be free
	assign any_store_op = dcache_store_i || dcache_flush_i || dcache_stbar_i;

	// Read after write bypass
	// Only the strand that owns the entry may see its pending data
	always_comb
	begin
		bypass_data = '0;
		bypass_mask = '0;
		if (store_enqueued[strand_i]
			&& store_tag[strand_i] == requested_tag_i
			&& store_set[strand_i] == requested_set_i)
		begin
			bypass_data = store_data[strand_i];
			bypass_mask = store_mask[strand_i];
		end
	end

	// Entries that hold work not yet taken by the L2 compete for the request port
	rr_arbiter #(
		.NUM_REQ(`STRAND_COUNT)
	) issue_arbiter (
		.clk(clk),
		.reset_n(reset_n),
		.request_i(store_enqueued & ~store_acknowledged),
		.advance_i(l2req_ready_i),
		.grant_oh_o(issue_oh)
	);

	always_comb
	begin
		issue_idx = '0;
		for (int k = 0; k < `STRAND_COUNT; k++)
		begin
			if (issue_oh[k])
				issue_idx = strand_t'(k);
		end
	end

	// A flush entry never carries store data, so it is checked first
	always_comb
	begin
		if (store_flush[issue_idx])
			l2req_op_o = L2OP_FLUSH;
		else if (store_synchronized[issue_idx])
			l2req_op_o = L2OP_STORE_SYNC;
		else
			l2req_op_o = L2OP_STORE;
	end

	assign l2req_valid_o = |issue_oh;
	assign l2req_unit_o = unit_t'(`UNIT_STBUF);
	assign l2req_strand_o = issue_idx;
	assign l2req_address_o = {store_tag[issue_idx], store_set[issue_idx]};
	assign l2req_data_o = store_data[issue_idx];
	assign l2req_mask_o = store_mask[issue_idx];

	// Responses for other units pass by untouched
	assign rsp_for_stbuf = l2rsp_valid_i && l2rsp_unit_i == unit_t'(`UNIT_STBUF);
	assign l2_ack_mask = rsp_for_stbuf
		? {{(`STRAND_COUNT-1){1'b0}}, 1'b1} << l2rsp_strand_i : '0;
	assign l2_store_complete = rsp_for_stbuf && store_enqueued[l2rsp_strand_i];

	// The L1 line is refreshed in the same cycle the L2 reports the update
	assign store_update_o = rsp_for_stbuf && l2rsp_update_i;
	assign store_update_set_o = rsp_for_stbuf ? store_set[l2rsp_strand_i] : '0;

	// The entry frees up in the same cycle the strand wants it again
	// The new request then takes over the entry directly
	assign store_collision = l2_store_complete && any_store_op && strand_i == l2rsp_strand_i;

	// A synchronized store is only sent once, the retry picks up the result
	assign sync_req_mask = (synchronized_i && dcache_store_i && !store_enqueued[strand_i])
		? strand_mask : '0;
	assign need_sync_rollback = |(sync_req_mask & ~sync_store_complete);

	assign enqueue = (dcache_store_i || dcache_flush_i)
		&& (!store_enqueued[strand_i] || store_collision)
		&& (!synchronized_i || need_sync_rollback);

	assign rollback_o = stbuf_full || need_sync_rollback_latched;
	assign store_count_o = store_count;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			store_enqueued <= '0;
			store_acknowledged <= '0;
			store_wait_strands <= '0;
			stbuf_full <= 1'b0;
			store_resume_strands_o <= '0;
			sync_store_wait <= '0;
			sync_store_complete <= '0;
			sync_store_result <= '0;
			need_sync_rollback_latched <= 1'b0;
			store_count <= '0;
		end
		else
		begin
			// Occupied entry means the strand must retry after the response
			if (any_store_op && store_enqueued[strand_i] && !store_collision)
			begin
				store_wait_strands <= (store_wait_strands & ~l2_ack_mask) | strand_mask;
				stbuf_full <= 1'b1;
			end
			else
			begin
				store_wait_strands <= store_wait_strands & ~l2_ack_mask;
				stbuf_full <= 1'b0;
			end

			// Resume comes one cycle late so it never lands before the rollback
			store_resume_strands_o <= (l2_ack_mask & store_wait_strands)
				| (l2_ack_mask & sync_store_wait);

			if (enqueue)
			begin
				store_enqueued[strand_i] <= 1'b1;
				if (dcache_store_i)
					store_count <= store_count + 64'd1;
			end

			// Granted entry is taken by the L2 when ready is high
			if (l2req_valid_o && l2req_ready_i)
				store_acknowledged[issue_idx] <= 1'b1;

			if (l2_store_complete)
			begin
				if (!store_collision)
					store_enqueued[l2rsp_strand_i] <= 1'b0;
				store_acknowledged[l2rsp_strand_i] <= 1'b0;
			end

			// Waiting ends at the ack, complete lasts until the retry consumes it
			sync_store_wait <= (sync_store_wait | (sync_req_mask & ~sync_store_complete))
				& ~l2_ack_mask;
			sync_store_complete <= (sync_store_complete | (sync_store_wait & l2_ack_mask))
				& ~sync_req_mask;
			if (|(l2_ack_mask & sync_store_wait))
				sync_store_result[l2rsp_strand_i] <= l2rsp_status_i;

			need_sync_rollback_latched <= need_sync_rollback;
		end
	end

	// Payload follows the enqueue, the control bits above say whether it is live
	always_ff @(posedge clk)
	begin
		if (enqueue)
		begin
			store_tag[strand_i] <= requested_tag_i;
			store_set[strand_i] <= requested_set_i;
			store_data[strand_i] <= data_i;
			store_mask[strand_i] <= mask_i;
			store_flush[strand_i] <= dcache_flush_i;
			store_synchronized[strand_i] <= synchronized_i;
		end

		// A synchronized store returns its L2 status in bit 0 of each word
		if (synchronized_i && dcache_store_i)
		begin
			data_o <= {(`LINE_WIDTH/32){{31{1'b0}}, sync_store_result[strand_i]}};
			mask_o <= {`MASK_WIDTH{1'b1}};
		end
		else
		begin
			data_o <= bypass_data;
			mask_o <= bypass_mask;
		end
	end

endmodule

/* store_path_top.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module store_path_top
(
	input  logic                                         clk,
	input  logic                                         reset_n,

	// Strand pipeline request
	input  logic                                         dcache_store_i,
	input  logic                                         dcache_flush_i,
	input  logic                                         dcache_stbar_i,
	input  logic                                         synchronized_i,
	input  cache_pkg::strand_t                           strand_i,
	input  logic [`L1_TAG_WIDTH-1:0]                     requested_tag_i,
	input  logic [`L1_SET_INDEX_WIDTH-1:0]               requested_set_i,
	input  logic [`LINE_WIDTH-1:0]                       data_i,
	input  logic [`MASK_WIDTH-1:0]                       mask_i,

	// Strand pipeline results
	output logic [`LINE_WIDTH-1:0]                       data_o,
	output logic [`MASK_WIDTH-1:0]                       mask_o,
	output logic                                         rollback_o,
	output logic [`STRAND_COUNT-1:0]                     store_resume_strands_o,
	output logic                                         store_update_o,
	output logic [`L1_SET_INDEX_WIDTH-1:0]               store_update_set_o,

	// L2 request
	output logic                                         l2req_valid_o,
	input  logic                                         l2req_ready_i,
	output cache_pkg::l2_op_t                            l2req_op_o,
	output cache_pkg::unit_t                             l2req_unit_o,
	output cache_pkg::strand_t                           l2req_strand_o,
	output logic [`L1_TAG_WIDTH+`L1_SET_INDEX_WIDTH-1:0] l2req_address_o,
	output logic [`LINE_WIDTH-1:0]                       l2req_data_o,
	output logic [`MASK_WIDTH-1:0]                       l2req_mask_o,

	// L2 response
	input  logic                                         l2rsp_valid_i,
	input  cache_pkg::unit_t                             l2rsp_unit_i,
	input  cache_pkg::strand_t                           l2rsp_strand_i,
	input  logic                                         l2rsp_status_i,
	input  logic                                         l2rsp_update_i,

	// Performance counter
	output logic [63:0]                                  store_count_o
);

	// Store path between the strand pipeline and the L2 interface
	store_buffer stbuf (
		.clk(clk),
		.reset_n(reset_n),
		.dcache_store_i(dcache_store_i),
		.dcache_flush_i(dcache_flush_i),
		.dcache_stbar_i(dcache_stbar_i),
		.synchronized_i(synchronized_i),
		.strand_i(strand_i),
		.requested_tag_i(requested_tag_i),
		.requested_set_i(requested_set_i),
		.data_i(data_i),
		.mask_i(mask_i),
		.data_o(data_o),
		.mask_o(mask_o),
		.rollback_o(rollback_o),
		.store_resume_strands_o(store_resume_strands_o),
		.store_update_o(store_update_o),
		.store_update_set_o(store_update_set_o),
		.l2req_valid_o(l2req_valid_o),
		.l2req_ready_i(l2req_ready_i),
		.l2req_op_o(l2req_op_o),
		.l2req_unit_o(l2req_unit_o),
		.l2req_strand_o(l2req_strand_o),
		.l2req_address_o(l2req_address_o),
		.l2req_data_o(l2req_data_o),
		.l2req_mask_o(l2req_mask_o),
		.l2rsp_valid_i(l2rsp_valid_i),
		.l2rsp_unit_i(l2rsp_unit_i),
		.l2rsp_strand_i(l2rsp_strand_i),
		.l2rsp_status_i(l2rsp_status_i),
		.l2rsp_update_i(l2rsp_update_i),
		.store_count_o(store_count_o)
	);

endmodule

/* tb_store_path.sv */
`timescale 1ns/1ps

`include "cache_macros.svh"

module tb_store_path;

	import cache_pkg::*;

	// Request word is op, strand, unit, address, data and mask
	localparam int REQ_W = 7 + `L1_TAG_WIDTH + `L1_SET_INDEX_WIDTH + `LINE_WIDTH + `MASK_WIDTH;
	localparam int TEST_CYCLES = 200;

	logic clk;
	logic reset_n;
	logic dcache_store_i;
	logic dcache_flush_i;
	logic dcache_stbar_i;
	logic synchronized_i;
	strand_t strand_i;
	logic [`L1_TAG_WIDTH-1:0] requested_tag_i;
	logic [`L1_SET_INDEX_WIDTH-1:0] requested_set_i;
	logic [`LINE_WIDTH-1:0] data_i;
	logic [`MASK_WIDTH-1:0] mask_i;
	logic [`LINE_WIDTH-1:0] data_o;
	logic [`MASK_WIDTH-1:0] mask_o;
	logic rollback_o;
	logic [`STRAND_COUNT-1:0] store_resume_strands_o;
	logic store_update_o;
	logic [`L1_SET_INDEX_WIDTH-1:0] store_update_set_o;
	logic l2req_valid_o;
	logic l2req_ready_i;
	l2_op_t l2req_op_o;
	unit_t l2req_unit_o;
	strand_t l2req_strand_o;
	logic [`L1_TAG_WIDTH+`L1_SET_INDEX_WIDTH-1:0] l2req_address_o;
	logic [`LINE_WIDTH-1:0] l2req_data_o;
	logic [`MASK_WIDTH-1:0] l2req_mask_o;
	logic l2rsp_valid_i;
	unit_t l2rsp_unit_i;
	strand_t l2rsp_strand_i;
	logic l2rsp_status_i;
	logic l2rsp_update_i;
	logic [63:0] store_count_o;

	// L2 model state, one slot per strand since each strand has one entry
	logic [`STRAND_COUNT-1:0] l2_pending;
	int l2_delay [`STRAND_COUNT];
	logic l2_status [`STRAND_COUNT];
	int low_left;
	logic ready_force_low;

	// Requests the DUT must issue, in the order they must be accepted
	logic [REQ_W-1:0] expect_q [$];
	logic [REQ_W-1:0] held_req;
	logic stalled;
	string cur_test;
	int errors;
	int test_start_errors;
	int tests_run;
	int tests_failed;
	longint exp_count;

	store_path_top UUT (.*);

	always #5 clk = ~clk;

	// Watchdog sized for six tests of up to 200 cycles each
	initial
	begin
		#(6 * TEST_CYCLES * 10);
		$display("Watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

	function automatic logic [REQ_W-1:0] predict_request(input logic flush, input logic sync,
		input strand_t s, input logic [`L1_TAG_WIDTH-1:0] tag,
		input logic [`L1_SET_INDEX_WIDTH-1:0] set, input logic [`LINE_WIDTH-1:0] data,
		input logic [`MASK_WIDTH-1:0] mask);
		l2_op_t op;
		// A flush wins over a synchronized store, a plain store is the default
		op = flush ? L2OP_FLUSH : (sync ? L2OP_STORE_SYNC : L2OP_STORE);
		return {op, s, unit_t'(`UNIT_STBUF), tag, set, data, mask};
	endfunction

	function automatic logic [`LINE_WIDTH+`MASK_WIDTH-1:0] predict_load(input logic hit,
		input logic sync_retry, input logic status, input logic [`LINE_WIDTH-1:0] data,
		input logic [`MASK_WIDTH-1:0] mask);
		logic [`LINE_WIDTH-1:0] words;
		// Status sits in bit 0 of every 32 bit word, all bytes enabled
		for (int i = 0; i < `LINE_WIDTH / 32; i++)
			words[i*32 +: 32] = {31'b0, status};
		if (sync_retry)
			return {words, {`MASK_WIDTH{1'b1}}};
		return hit ? {data, mask} : '0;
	endfunction

	function automatic logic [`LINE_WIDTH-1:0] random_line();
		logic [`LINE_WIDTH-1:0] v;
		for (int i = 0; i < `LINE_WIDTH / 32; i++)
			v[i*32 +: 32] = $urandom;
		return v;
	endfunction

	task automatic check_value(input string what, input logic [639:0] expected,
		input logic [639:0] actual);
		if (expected !== actual)
		begin
			$display("FAIL %s %s expected %0h actual %0h", cur_test, what, expected, actual);
			errors++;
		end
	endtask

	// L2 responder with random ready stalls and a random latency of 1 to 8 cycles
	always @(posedge clk or negedge reset_n)
	begin
		logic sent;
		logic st;
		if (!reset_n)
		begin
			l2req_ready_i <= 1'b0;
			l2rsp_valid_i <= 1'b0;
			l2_pending = '0;
			low_left = 0;
		end
		else
		begin
			sent = 1'b0;
			l2rsp_valid_i <= 1'b0;
			for (int k = 0; k < `STRAND_COUNT; k++)
			begin
				if (l2_pending[k] && l2_delay[k] > 0)
					l2_delay[k]--;
				if (!sent && l2_pending[k] && l2_delay[k] == 0)
				begin
					st = $urandom % 2;
					l2_status[k] = st;
					l2_pending[k] = 1'b0;
					sent = 1'b1;
					l2rsp_valid_i <= 1'b1;
					l2rsp_unit_i <= unit_t'(`UNIT_STBUF);
					l2rsp_strand_i <= strand_t'(k);
					l2rsp_status_i <= st;
					l2rsp_update_i <= 1'b1;
				end
			end
			if (l2req_valid_o && l2req_ready_i)
			begin
				l2_pending[l2req_strand_o] = 1'b1;
				l2_delay[l2req_strand_o] = $urandom_range(1, 8);
			end
			if (ready_force_low)
				l2req_ready_i <= 1'b0;
			else if (low_left > 0)
			begin
				low_left--;
				l2req_ready_i <= 1'b0;
			end
			else if ($urandom % 4 == 0)
			begin
				low_left = $urandom_range(1, 4);
				l2req_ready_i <= 1'b0;
			end
			else
				l2req_ready_i <= 1'b1;
		end
	end

	// Compares every accepted request and checks that stalled ones hold still
	always @(posedge clk)
	begin
		logic [REQ_W-1:0] actual;
		actual = {l2req_op_o, l2req_strand_o, l2req_unit_o, l2req_address_o,
			l2req_data_o, l2req_mask_o};
		if (reset_n)
		begin
			if (stalled && !l2req_valid_o)
			begin
				$display("Stalled L2 request was withdrawn during %s", cur_test);
				errors++;
			end
			else if (stalled)
				check_value("held request", held_req, actual);
			stalled = 1'b0;
			if (l2req_valid_o && l2req_ready_i)
			begin
				if (expect_q.size() == 0)
				begin
					$display("Unexpected L2 request from strand %0d during %s",
						l2req_strand_o, cur_test);
					errors++;
				end
				else
					check_value("request", expect_q.pop_front(), actual);
			end
			else if (l2req_valid_o)
			begin
				stalled = 1'b1;
				held_req = actual;
			end
		end
	end

	// One pipeline request lasting one cycle, returns at the negedge after it was taken
	task automatic drive_op(input logic st, input logic fl, input logic sb, input logic sy,
		input strand_t s, input logic [`L1_TAG_WIDTH-1:0] tag,
		input logic [`L1_SET_INDEX_WIDTH-1:0] set, input logic [`LINE_WIDTH-1:0] data,
		input logic [`MASK_WIDTH-1:0] mask);
		@(posedge clk);
		dcache_store_i <= st;
		dcache_flush_i <= fl;
		dcache_stbar_i <= sb;
		synchronized_i <= sy;
		strand_i <= s;
		requested_tag_i <= tag;
		requested_set_i <= set;
		data_i <= data;
		mask_i <= mask;
		@(posedge clk);
		dcache_store_i <= 1'b0;
		dcache_flush_i <= 1'b0;
		dcache_stbar_i <= 1'b0;
		synchronized_i <= 1'b0;
		@(negedge clk);
	endtask

	// Returns at the negedge inside the response cycle for strand s
	task automatic wait_response(input strand_t s);
		int n;
		n = 0;
		while (!(l2rsp_valid_i && l2rsp_strand_i == s) && n < TEST_CYCLES)
		begin
			@(negedge clk);
			n++;
		end
		if (n == TEST_CYCLES)
		begin
			$display("No L2 response for strand %0d during %s", s, cur_test);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_start_errors = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_start_errors)
			$display("test %s: ok", cur_test);
		else
		begin
			$display("test %s: %0d errors", cur_test, errors - test_start_errors);
			tests_failed++;
		end
	endtask

	task automatic test_plain_store();
		logic [`L1_TAG_WIDTH-1:0] tag;
		logic [`L1_SET_INDEX_WIDTH-1:0] set;
		logic [`LINE_WIDTH-1:0] data;
		logic [`MASK_WIDTH-1:0] mask;
		start_test("plain_store");
		for (int s = 0; s < `STRAND_COUNT; s++)
		begin
			tag = $urandom;
			set = $urandom;
			data = random_line();
			mask = {$urandom, $urandom};
			expect_q.push_back(predict_request(1'b0, 1'b0, strand_t'(s), tag, set, data, mask));
			exp_count++;
			drive_op(1, 0, 0, 0, strand_t'(s), tag, set, data, mask);
			wait_response(strand_t'(s));
		end
		end_test();
	endtask

	task automatic test_bypass();
		logic [`L1_TAG_WIDTH-1:0] tag;
		logic [`L1_SET_INDEX_WIDTH-1:0] set;
		logic [`LINE_WIDTH-1:0] data;
		logic [`MASK_WIDTH-1:0] mask;
		start_test("bypass");
		tag = $urandom;
		set = $urandom;
		data = random_line();
		mask = {$urandom, $urandom};
		// Ready stays low so the entry is still pending during the loads
		ready_force_low = 1'b1;
		expect_q.push_back(predict_request(1'b0, 1'b0, 2'd1, tag, set, data, mask));
		exp_count++;
		drive_op(1, 0, 0, 0, 2'd1, tag, set, data, mask);
		drive_op(0, 0, 0, 0, 2'd1, tag, set, '0, '0);
		check_value("same line", predict_load(1, 0, 0, data, mask), {data_o, mask_o});
		drive_op(0, 0, 0, 0, 2'd2, tag, set, '0, '0);
		check_value("other strand", predict_load(0, 0, 0, data, mask), {data_o, mask_o});
		drive_op(0, 0, 0, 0, 2'd1, tag, set + 1'b1, '0, '0);
		check_value("other line", predict_load(0, 0, 0, data, mask), {data_o, mask_o});
		ready_force_low = 1'b0;
		wait_response(2'd1);
		end_test();
	endtask

	task automatic test_rollback();
		logic [`LINE_WIDTH-1:0] data_a;
		logic [`LINE_WIDTH-1:0] data_b;
		start_test("rollback");
		data_a = random_line();
		data_b = random_line();
		expect_q.push_back(predict_request(1'b0, 1'b0, 2'd0, 16'h1234, 10'h055, data_a, '1));
		exp_count++;
		drive_op(1, 0, 0, 0, 2'd0, 16'h1234, 10'h055, data_a, '1);
		// The entry is still occupied, so this store must roll back
		drive_op(1, 0, 0, 0, 2'd0, 16'h1234, 10'h056, data_b, '1);
		check_value("rollback", 1'b1, rollback_o);
		wait_response(2'd0);
		@(negedge clk);
		check_value("resume", 4'b0001, store_resume_strands_o);
		expect_q.push_back(predict_request(1'b0, 1'b0, 2'd0, 16'h1234, 10'h056, data_b, '1));
		exp_count++;
		drive_op(1, 0, 0, 0, 2'd0, 16'h1234, 10'h056, data_b, '1);
		check_value("retry rollback", 1'b0, rollback_o);
		wait_response(2'd0);
		end_test();
	endtask

	task automatic test_flush();
		logic [`LINE_WIDTH-1:0] data;
		start_test("flush");
		data = random_line();
		expect_q.push_back(predict_request(1'b1, 1'b0, 2'd2, 16'hbeef, 10'h2a1, data, '0));
		drive_op(0, 1, 0, 0, 2'd2, 16'hbeef, 10'h2a1, data, '0);
		wait_response(2'd2);
		check_value("update", 1'b1, store_update_o);
		check_value("update set", 10'h2a1, store_update_set_o);
		end_test();
	endtask

	task automatic test_sync_store();
		logic [`LINE_WIDTH-1:0] data;
		start_test("sync_store");
		data = random_line();
		expect_q.push_back(predict_request(1'b0, 1'b1, 2'd3, 16'h0f0f, 10'h301, data, '1));
		exp_count++;
		drive_op(1, 0, 0, 1, 2'd3, 16'h0f0f, 10'h301, data, '1);
		check_value("first rollback", 1'b1, rollback_o);
		wait_response(2'd3);
		@(negedge clk);
		check_value("resume", 4'b1000, store_resume_strands_o);
		// The retry gets the recorded status and sends nothing to the L2
		drive_op(1, 0, 0, 1, 2'd3, 16'h0f0f, 10'h301, data, '1);
		check_value("retry rollback", 1'b0, rollback_o);
		check_value("status", predict_load(0, 1, l2_status[3], data, '1), {data_o, mask_o});
		repeat (10) @(negedge clk);
		end_test();
	endtask

	task automatic test_round_robin();
		logic [`LINE_WIDTH-1:0] data [`STRAND_COUNT];
		int arrival [`STRAND_COUNT];
		int s;
		int n;
		start_test("round_robin");
		// Strand 2 arrives first and keeps the grant while ready is low
		arrival[0] = 2;
		arrival[1] = 0;
		arrival[2] = 1;
		arrival[3] = 3;
		for (int i = 0; i < `STRAND_COUNT; i++)
			data[i] = random_line();
		// Priority then moves past strand 2 and wraps around to strand 1
		for (int i = 0; i < `STRAND_COUNT; i++)
		begin
			s = (arrival[0] + i) % `STRAND_COUNT;
			expect_q.push_back(predict_request(1'b0, 1'b0, strand_t'(s), 16'(16'h4400 + s),
				10'(10'h100 + s), data[s], '1));
			exp_count++;
		end
		ready_force_low = 1'b1;
		for (int i = 0; i < `STRAND_COUNT; i++)
		begin
			s = arrival[i];
			drive_op(1, 0, 0, 0, strand_t'(s), 16'(16'h4400 + s), 10'(10'h100 + s),
				data[s], '1);
		end
		ready_force_low = 1'b0;
		n = 0;
		while ((expect_q.size() != 0 || |l2_pending || l2rsp_valid_i) && n < TEST_CYCLES)
		begin
			@(negedge clk);
			n++;
		end
		if (n == TEST_CYCLES)
		begin
			$display("Store buffer did not drain during %s", cur_test);
			errors++;
		end
		check_value("store count", exp_count, store_count_o);
		end_test();
	endtask

	initial
	begin
		void'($urandom(32'h14c2));
		clk = 1'b0;
		reset_n = 1'b0;
		dcache_store_i = 1'b0;
		dcache_flush_i = 1'b0;
		dcache_stbar_i = 1'b0;
		synchronized_i = 1'b0;
		strand_i = '0;
		requested_tag_i = '0;
		requested_set_i = '0;
		data_i = '0;
		mask_i = '0;
		l2req_ready_i = 1'b0;
		l2rsp_valid_i = 1'b0;
		l2rsp_unit_i = '0;
		l2rsp_strand_i = '0;
		l2rsp_status_i = 1'b0;
		l2rsp_update_i = 1'b0;
		ready_force_low = 1'b0;
		stalled = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		exp_count = 0;
		repeat (2) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		check_value("reset outputs", 7'b0,
			{l2req_valid_o, rollback_o, store_update_o, store_resume_strands_o});
		test_plain_store();
		test_bypass();
		test_rollback();
		test_flush();
		test_sync_store();
		test_round_robin();
		if (expect_q.size() != 0)
		begin
			$display("%0d expected L2 requests were never issued", expect_q.size());
			errors++;
		end
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule
